// File: design/bcast_pkg.sv
/*
 * bcast_pkg
 * Sizes, command and response encodings, and the packed command and
 * response records shared by every block of the broadcast bus fabric.
 */
package bcast_pkg;

  localparam int num_targets  = 4;
  localparam int addr_width   = 16;
  localparam int data_width   = 32;
  localparam int id_width     = 4;
  localparam int target_words = 12;  // words 12 to 15 are unimplemented.

  localparam bit enable_bcast_non_posted = 1'b1;

  // target select sits in the top address bits, the word index in the bottom ones.
  localparam int target_sel_width = $clog2(num_targets);
  localparam int word_sel_width   = 4;

  typedef enum logic [2:0] {
    cmd_read     = 3'd0,
    cmd_write    = 3'd1,  // posted, no response.
    cmd_write_np = 3'd2,
    cmd_bcast    = 3'd3,  // posted write to all targets.
    cmd_bcast_np = 3'd4
  } bus_cmd_e;

  typedef enum logic {
    resp_read  = 1'b0,
    resp_write = 1'b1
  } bus_resp_e;

  typedef struct packed {
    bus_cmd_e                cmd;
    logic [id_width-1:0]     id;
    logic [addr_width-1:0]   addr;
    logic [data_width-1:0]   data;
    logic [data_width/8-1:0] byteen;
  } bus_cmd_t;

  typedef struct packed {
    bus_resp_e             resp;
    logic [id_width-1:0]   id;
    logic                  error;
    logic [data_width-1:0] data;
    logic                  bcast;  // set for the answer to a non-posted broadcast.
  } bus_resp_t;

endpackage

// File: design/bcast_forcer.sv
/*
 * bcast_forcer
 * Entry stage of the fabric. While force_broadcast is high, posted
 * writes become broadcasts, and non-posted writes become non-posted
 * broadcasts when that option is on. The handshake passes straight through.
 */
`timescale 1ns/1ps

module bcast_forcer (
  input  logic                force_broadcast,
  input  logic                in_valid,
  input  bcast_pkg::bus_cmd_t in_cmd,
  output logic                in_accept,
  output logic                out_valid,
  output bcast_pkg::bus_cmd_t out_cmd,
  input  logic                out_accept
);
  import bcast_pkg::*;

  function automatic bus_cmd_e forced_cmd(bus_cmd_e cmd, logic force_en);
    bus_cmd_e result;
    result = cmd;
    if (force_en && (cmd == cmd_write)) begin
      result = cmd_bcast;
    end else if (force_en && enable_bcast_non_posted && (cmd == cmd_write_np)) begin
      result = cmd_bcast_np;
    end
    return result;
  endfunction

  always_comb begin
    in_accept   = out_accept;  // no storage here, so accept is the downstream one.
    out_valid   = in_valid;
    out_cmd     = in_cmd;
    out_cmd.cmd = forced_cmd(in_cmd.cmd, force_broadcast);  // only the opcode changes.
  end

endmodule

// File: design/bcast_fanout.sv
/*
 * bcast_fanout
 * Registers one command and offers it to a single target chosen by the
 * top address bits, or to every target for a broadcast. A pending mask
 * tracks which targets still have to take the command; each bit clears
 * on its own target's accept, so targets may take a broadcast at
 * different times.
 */
`timescale 1ns/1ps

module bcast_fanout (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid,
  input  bcast_pkg::bus_cmd_t in_cmd,
  output logic                in_accept,
  output logic                tgt_valid [bcast_pkg::num_targets],
  output bcast_pkg::bus_cmd_t tgt_cmd,
  input  logic                tgt_accept [bcast_pkg::num_targets]
);
  import bcast_pkg::*;

  logic [num_targets-1:0]      pending;
  logic [num_targets-1:0]      load_mask;
  logic [num_targets-1:0]      taken;
  logic [target_sel_width-1:0] sel;
  logic                        is_bcast;
  logic                        load;
  bus_cmd_t                    cmd_q;

  assign in_accept = (pending == '0);  // one command in flight at a time.
  assign load      = in_valid && in_accept;

  // decode the destination of the incoming command.
  always_comb begin
    sel       = in_cmd.addr[addr_width-1 -: target_sel_width];
    is_bcast  = (in_cmd.cmd == cmd_bcast) || (in_cmd.cmd == cmd_bcast_np);
    load_mask = '0;
    if (is_bcast) begin
      load_mask = '1;
    end else begin
      load_mask[sel] = 1'b1;
    end
  end

  always_comb begin
    for (int i = 0; i < num_targets; i++) begin
      tgt_valid[i] = pending[i];
      taken[i]     = pending[i] && tgt_accept[i];  // target i has its copy now.
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else if (load) begin
      pending <= load_mask;
    end else begin
      pending <= pending & ~taken;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cmd_q <= in_cmd;
    end
  end

  assign tgt_cmd = cmd_q;  // every target sees the same payload.

endmodule

// File: design/bcast_target.sv
/*
 * bcast_target
 * One register bank behind the fabric. Executes reads and writes with
 * byte enables, ignores the target bits of the address, flags accesses
 * past the implemented words, and returns one registered response for
 * each read or non-posted write.
 */
`timescale 1ns/1ps

module bcast_target (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cmd_valid,
  input  bcast_pkg::bus_cmd_t  cmd,
  output logic                 cmd_accept,
  output logic                 resp_valid,
  output bcast_pkg::bus_resp_t resp,
  input  logic                 resp_accept
);
  import bcast_pkg::*;

  logic [data_width-1:0]     regs [target_words];
  logic [word_sel_width-1:0] word;
  logic                      in_range;
  logic                      is_write;
  logic                      needs_resp;
  logic                      take;
  bus_resp_t                 next_resp;

  assign cmd_accept = !resp_valid || resp_accept;  // room once the old response leaves.
  assign take       = cmd_valid && cmd_accept;

  always_comb begin
    word       = cmd.addr[word_sel_width-1:0];
    in_range   = (int'(word) < target_words);
    is_write   = cmd.cmd inside {cmd_write, cmd_write_np, cmd_bcast, cmd_bcast_np};
    needs_resp = cmd.cmd inside {cmd_read, cmd_write_np, cmd_bcast_np};

    next_resp       = '0;
    next_resp.resp  = (cmd.cmd == cmd_read) ? resp_read : resp_write;
    next_resp.id    = cmd.id;
    next_resp.error = !in_range;
    next_resp.bcast = (cmd.cmd == cmd_bcast_np);
    if ((cmd.cmd == cmd_read) && in_range) begin
      next_resp.data = regs[word];  // out of range reads return zero.
    end
  end

  always_ff @(posedge clk) begin
    if (take && is_write && in_range) begin
      for (int b = 0; b < data_width / 8; b++) begin
        if (cmd.byteen[b]) begin
          regs[word][8*b +: 8] <= cmd.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (take && needs_resp) begin
      resp_valid <= 1'b1;
    end else if (resp_accept) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take && needs_resp) begin
      resp <= next_resp;
    end
  end

endmodule

// File: design/bcast_resp_merger.sv
/*
 * bcast_resp_merger
 * Collects the target responses into the single response channel.
 * Unicast responses go through a round-robin arbiter. Broadcast
 * responses wait until every target has one, are all taken in one cycle
 * and leave as a single response with the errors ORed together.
 */
`timescale 1ns/1ps

module bcast_resp_merger (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tgt_resp_valid [bcast_pkg::num_targets],
  input  bcast_pkg::bus_resp_t tgt_resp [bcast_pkg::num_targets],
  output logic                 tgt_resp_accept [bcast_pkg::num_targets],
  output logic                 resp_valid,
  output bcast_pkg::bus_resp_t resp,
  input  logic                 resp_accept
);
  import bcast_pkg::*;

  logic [num_targets-1:0]      uni_req;
  logic [num_targets-1:0]      bc_req;
  logic [num_targets-1:0]      err_vec;
  logic [num_targets-1:0]      grant;
  logic [target_sel_width-1:0] grant_idx;
  logic [target_sel_width-1:0] rr_ptr;
  logic                        bc_all;
  logic                        out_free;
  logic                        take;
  bus_resp_t                   merged;

  always_comb begin
    for (int i = 0; i < num_targets; i++) begin
      uni_req[i] = tgt_resp_valid[i] && !tgt_resp[i].bcast;
      bc_req[i]  = tgt_resp_valid[i] && tgt_resp[i].bcast;
      err_vec[i] = tgt_resp[i].error;
    end
    bc_all   = &bc_req;  // a broadcast is complete only when all targets answered.
    out_free = !resp_valid || resp_accept;
    take     = bc_all || (|uni_req);
  end

  // round-robin search starting at rr_ptr.
  always_comb begin
    int idx;
    grant     = '0;
    grant_idx = rr_ptr;
    for (int k = 0; k < num_targets; k++) begin
      idx = (int'(rr_ptr) + k) % num_targets;
      if (uni_req[idx] && (grant == '0)) begin
        grant[idx] = 1'b1;
        grant_idx  = target_sel_width'(idx);
      end
    end
  end

  always_comb begin
    merged = tgt_resp[grant_idx];
    if (bc_all) begin
      merged       = tgt_resp[0];  // every copy carries the same id.
      merged.resp  = resp_write;
      merged.data  = '0;
      merged.error = |err_vec;
    end
    for (int i = 0; i < num_targets; i++) begin
      tgt_resp_accept[i] = out_free && (bc_all || grant[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
      rr_ptr     <= '0;
    end else if (out_free) begin
      resp_valid <= take;
      if (!bc_all && (|uni_req)) begin
        rr_ptr <= grant_idx + target_sel_width'(1);  // the winner drops to lowest priority.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_free && take) begin
      resp <= merged;
    end
  end

endmodule

// File: design/bcast_top.sv
/*
 * bcast_top
 * Broadcast bus fabric: forcer at the entry, fan-out to the register
 * bank targets, and the response merger back to the initiator.
 */
`timescale 1ns/1ps

module bcast_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 force_broadcast,
  input  logic                 cmd_valid,
  input  bcast_pkg::bus_cmd_t  cmd,
  output logic                 cmd_accept,
  output logic                 resp_valid,
  output bcast_pkg::bus_resp_t resp,
  input  logic                 resp_accept
);
  import bcast_pkg::*;

  logic      fwd_valid;
  logic      fwd_accept;
  bus_cmd_t  fwd_cmd;
  bus_cmd_t  tgt_cmd;
  logic      tgt_valid [num_targets];
  logic      tgt_accept [num_targets];
  logic      tgt_resp_valid [num_targets];
  logic      tgt_resp_accept [num_targets];
  bus_resp_t tgt_resp [num_targets];

  bcast_forcer u_forcer (
    .force_broadcast (force_broadcast),
    .in_valid        (cmd_valid),
    .in_cmd          (cmd),
    .in_accept       (cmd_accept),
    .out_valid       (fwd_valid),
    .out_cmd         (fwd_cmd),
    .out_accept      (fwd_accept)
  );

  bcast_fanout u_fanout (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (fwd_valid),
    .in_cmd     (fwd_cmd),
    .in_accept  (fwd_accept),
    .tgt_valid  (tgt_valid),
    .tgt_cmd    (tgt_cmd),
    .tgt_accept (tgt_accept)
  );

  for (genvar i = 0; i < num_targets; i++) begin : g_target
    bcast_target u_target (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid   (tgt_valid[i]),
      .cmd         (tgt_cmd),
      .cmd_accept  (tgt_accept[i]),
      .resp_valid  (tgt_resp_valid[i]),
      .resp        (tgt_resp[i]),
      .resp_accept (tgt_resp_accept[i])
    );
  end

  bcast_resp_merger u_merger (
    .clk             (clk),
    .rst             (rst),
    .tgt_resp_valid  (tgt_resp_valid),
    .tgt_resp        (tgt_resp),
    .tgt_resp_accept (tgt_resp_accept),
    .resp_valid      (resp_valid),
    .resp            (resp),
    .resp_accept     (resp_accept)
  );

endmodule

// File: dv/bcast_chk.sv
/*
 * bcast_chk
 * Protocol checker bound into the fabric top level. Watches the
 * command and response handshakes for held valids, stable payloads
 * and quiet responses while reset is applied.
 */
`timescale 1ns/1ps

module bcast_chk (
  input logic                 clk,
  input logic                 rst,
  input logic                 cmd_valid,
  input bcast_pkg::bus_cmd_t  cmd,
  input logic                 cmd_accept,
  input logic                 resp_valid,
  input bcast_pkg::bus_resp_t resp,
  input logic                 resp_accept
);
  import bcast_pkg::*;

  a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
    cmd_valid && !cmd_accept |=> cmd_valid)
    else $error("command valid dropped before accept");

  a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
    cmd_valid && !cmd_accept |=> $stable(cmd))
    else $error("command payload changed while stalled");

  a_resp_hold: assert property (@(posedge clk) disable iff (rst)
    resp_valid && !resp_accept |=> resp_valid)
    else $error("response valid dropped before accept");

  a_resp_stable: assert property (@(posedge clk) disable iff (rst)
    resp_valid && !resp_accept |=> $stable(resp))
    else $error("response payload changed while stalled");

  // the first reset edge only clears the register, so look one edge later.
  a_no_resp_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> !resp_valid)
    else $error("response valid during reset");

endmodule

bind bcast_top bcast_chk chk_i (
  .clk         (clk),
  .rst         (rst),
  .cmd_valid   (cmd_valid),
  .cmd         (cmd),
  .cmd_accept  (cmd_accept),
  .resp_valid  (resp_valid),
  .resp        (resp),
  .resp_accept (resp_accept)
);

// File: dv/bcast_tb.sv
/*
 * bcast_tb
 * Testbench for the broadcast bus fabric. Drives unicast, forced
 * broadcast and out of range accesses, predicts every response from a
 * shadow copy of the target register banks and compares the responses
 * in order while the response channel is randomly stalled.
 */
`timescale 1ns/1ps

module bcast_tb;
  import bcast_pkg::*;

  logic      clk;
  logic      rst;
  logic      force_broadcast;
  logic      cmd_valid;
  bus_cmd_t  cmd;
  logic      cmd_accept;
  logic      resp_valid;
  bus_resp_t resp;
  logic      resp_accept;

  logic [data_width-1:0] shadow [num_targets][target_words];
  bus_resp_t             expq[$];
  int                    wait_limit = 200;

  bcast_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic report_failure(string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      report_failure("response mismatch");
    end
  endtask

  // the reference model applies the forcing rule, the word range rule and the byte enables.
  function automatic bit predict(input bus_cmd_t c, input logic force_on,
                                 output bus_resp_t r);
    bus_cmd_e op;
    int       t;
    int       w;
    bit       all;
    op = c.cmd;
    if (force_on && (op == cmd_write)) op = cmd_bcast;
    if (force_on && enable_bcast_non_posted && (op == cmd_write_np)) op = cmd_bcast_np;
    t   = int'(c.addr[addr_width-1 -: 2]);
    w   = int'(c.addr[3:0]);
    all = (op == cmd_bcast) || (op == cmd_bcast_np);
    r       = '0;
    r.resp  = (op == cmd_read) ? resp_read : resp_write;
    r.id    = c.id;
    r.error = (w >= target_words);
    r.bcast = (op == cmd_bcast_np);
    if ((op == cmd_read) && (w < target_words)) r.data = shadow[t][w];
    if ((op != cmd_read) && (w < target_words)) begin
      for (int i = 0; i < num_targets; i++) begin
        for (int b = 0; b < data_width / 8; b++) begin
          if ((all || (i == t)) && c.byteen[b]) shadow[i][w][8*b +: 8] = c.data[8*b +: 8];
        end
      end
    end
    return (op != cmd_write) && (op != cmd_bcast);  // posted writes stay silent.
  endfunction

  task automatic send_cmd(bus_cmd_t c, logic force_on);
    int cycles;
    cycles          = 0;
    cmd             = c;
    force_broadcast = force_on;
    cmd_valid       = 1'b1;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) report_failure("command was not accepted in time");
    end while (!cmd_accept);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (expq.size() != 0) begin
      @(negedge clk);
      cycles++;
      if (cycles > wait_limit) report_failure("expected response did not arrive in time");
    end
  endtask

  // one command at a time, so the response order is fixed.
  task automatic run_op(bus_cmd_e op, logic force_on, int t, int w,
                        logic [data_width-1:0] data, logic [data_width/8-1:0] be);
    bus_cmd_t  c;
    bus_resp_t r;
    c.cmd    = op;
    c.id     = 4'($urandom);
    c.addr   = {2'(t), 10'($urandom), 4'(w)};  // middle bits must be ignored.
    c.data   = data;
    c.byteen = be;
    if (predict(c, force_on, r)) expq.push_back(r);
    send_cmd(c, force_on);
    wait_drained();
  endtask

  function automatic bus_cmd_e pick_op();
    case ($urandom % 3)
      0:       return cmd_read;
      1:       return cmd_write;
      default: return cmd_write_np;
    endcase
  endfunction

  initial begin
    resp_accept = 1'b0;
    forever begin
      @(negedge clk);
      resp_accept = ($urandom % 4) != 0;  // stall about one cycle in four.
    end
  end

  always @(posedge clk) begin : compare
    bus_resp_t exp;
    if (!rst && resp_valid && resp_accept) begin
      if (expq.size() == 0) begin
        report_failure("a response arrived while none was expected");
      end else begin
        exp = expq.pop_front();
        check("resp.resp", 32'(resp.resp), 32'(exp.resp));
        check("resp.id", 32'(resp.id), 32'(exp.id));
        check("resp.error", 32'(resp.error), 32'(exp.error));
        check("resp.data", resp.data, exp.data);
        check("resp.bcast", 32'(resp.bcast), 32'(exp.bcast));
      end
    end
  end

  initial begin
    int t;
    int w;
    void'($urandom(37));
    rst             = 1'b1;
    force_broadcast = 1'b0;
    cmd_valid       = 1'b0;
    cmd             = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // fill every implemented word so later reads are defined.
    for (int i = 0; i < num_targets; i++) begin
      for (int j = 0; j < target_words; j++) begin
        run_op(cmd_write, 1'b0, i, j, $urandom, 4'hf);
      end
    end
    repeat (20) begin
      t = $urandom % num_targets;
      w = $urandom % target_words;
      run_op(($urandom % 2) ? cmd_write : cmd_write_np, 1'b0, t, w, $urandom, 4'($urandom));
      run_op(cmd_read, 1'b0, t, w, '0, '0);
    end
    repeat (4) begin
      w = $urandom % target_words;
      run_op(cmd_write, 1'b1, $urandom % num_targets, w, $urandom, 4'($urandom));
      for (int i = 0; i < num_targets; i++) run_op(cmd_read, 1'b0, i, w, '0, '0);
      run_op(cmd_write_np, 1'b1, $urandom % num_targets, w, $urandom, 4'hf);
      w = $urandom % target_words;
      run_op(cmd_write_np, 1'b0, $urandom % num_targets, w, $urandom, 4'hf);
      for (int i = 0; i < num_targets; i++) run_op(cmd_read, 1'b0, i, w, '0, '0);
    end
    for (int j = target_words; j < 16; j++) begin
      run_op(cmd_read, 1'b0, $urandom % num_targets, j, '0, '0);
      run_op(cmd_write_np, 1'b0, $urandom % num_targets, j, $urandom, 4'hf);
      run_op(cmd_write_np, 1'b1, $urandom % num_targets, j, $urandom, 4'hf);
      run_op(cmd_write, 1'b1, $urandom % num_targets, j, $urandom, 4'hf);
    end
    repeat (300) begin
      run_op(pick_op(), 1'($urandom), $urandom % num_targets, $urandom % 16,
             $urandom, 4'($urandom));
    end

    repeat (20) @(negedge clk);  // room for a stray response to show up.
    $display("test passed");
    $finish;
  end

endmodule

// File: bcast.f
design/bcast_pkg.sv
design/bcast_forcer.sv
design/bcast_fanout.sv
design/bcast_target.sv
design/bcast_resp_merger.sv
design/bcast_top.sv
dv/bcast_chk.sv
dv/bcast_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module bcast_tb -f bcast.f -o bcast_sim
	./obj_dir/bcast_sim | tee /dev/stderr | grep -q "test passed"

clean:
	rm -rf obj_dir
